/* include/cache_mem_macros.svh */
`ifndef CACHE_MEM_MACROS_SVH
`define CACHE_MEM_MACROS_SVH

// cache line and wishbone sizes
`define LINE_BITS       128        // one cache line
`define LINE_ADDR_BITS  12         // line address
`define SEL_BITS        16         // one select per byte

// modelled line memory
`define MEM_LINES       64         // implemented lines
`define MEM_WAIT        2          // cycles from request seen to ack

// config register bus
`define CFG_ADDR_BITS   2          // four registers
`define CFG_DATA_BITS   32         // register width

`endif

/* source/cache_mem_pkg.sv */
`default_nettype none

`include "cache_mem_macros.svh"

package cache_mem_pkg;

    // master to slave
    typedef struct packed {
        logic [`LINE_BITS-1:0]      dat_m;
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`SEL_BITS-1:0]       sel;
        logic [`LINE_ADDR_BITS-1:0] adr;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic [`LINE_BITS-1:0] dat_s;
        logic                  ack;
        logic                  rty;
    } wb_rsp_t;

    typedef struct packed {
        logic                      stb;
        logic                      we;
        logic [`CFG_ADDR_BITS-1:0] adr;
        logic [`CFG_DATA_BITS-1:0] wdata;
    } cfg_req_t;

    typedef struct packed {
        logic                      ack;
        logic [`CFG_DATA_BITS-1:0] rdata;
    } cfg_rsp_t;

    typedef enum logic [1:0] {
        o_none,
        o_input0,
        o_input1
    } owner_t;

    typedef enum logic {
        mode_fixed,          // port 0 wins ties
        mode_alternate       // last loser wins ties
    } arb_mode_t;

endpackage

`default_nettype wire

/* source/wb_barrier.sv */
`timescale 1ns/100ps
`default_nettype none

// one register stage on a wishbone bundle, cuts the path into the arbiter
module wb_barrier #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      i_reset,
    input  payload_t i_d,
    output payload_t o_q
);

    // zero is idle for both bundles, so cyc/stb/ack come up low
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_q <= '0;
        end else begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

/* source/cache_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_arbiter (
    input  wire                           clk,
    input  wire                           i_reset,
    input  cache_mem_pkg::wb_req_t        i_port0,
    input  cache_mem_pkg::wb_req_t        i_port1,
    output cache_mem_pkg::wb_rsp_t        o_port0,
    output cache_mem_pkg::wb_rsp_t        o_port1,
    output cache_mem_pkg::wb_req_t        o_mem,
    input  cache_mem_pkg::wb_rsp_t        i_mem,
    input  cache_mem_pkg::arb_mode_t      i_mode,
    output logic                          o_grant,
    output cache_mem_pkg::owner_t         o_grant_owner
);

    // what a non-owner sees
    localparam cache_mem_pkg::wb_rsp_t rsp_idle = '{dat_s: '0, ack: 1'b0, rty: 1'b1};

    cache_mem_pkg::wb_req_t req0_q;    // registered port 0 request
    cache_mem_pkg::wb_req_t req1_q;    // registered port 1 request
    cache_mem_pkg::wb_rsp_t rsp_q;     // registered memory response

    cache_mem_pkg::owner_t owner;
    cache_mem_pkg::owner_t next_owner;
    logic last_was0;                   // port 0 held the last grant
    logic prefer1;                     // port 1 wins a tie
    logic new_grant;

    wb_barrier #(.payload_t(cache_mem_pkg::wb_req_t)) u_bar_port0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_d     (i_port0),
        .o_q     (req0_q)
    );

    wb_barrier #(.payload_t(cache_mem_pkg::wb_req_t)) u_bar_port1 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_d     (i_port1),
        .o_q     (req1_q)
    );

    wb_barrier #(.payload_t(cache_mem_pkg::wb_rsp_t)) u_bar_mem (
        .clk     (clk),
        .i_reset (i_reset),
        .i_d     (i_mem),
        .o_q     (rsp_q)
    );

    assign prefer1 = (i_mode == cache_mem_pkg::mode_alternate) && last_was0;

    // owner transitions, all from the registered requests
    always_comb begin
        next_owner = owner;
        case (owner)
            cache_mem_pkg::o_none: begin
                if (req0_q.cyc && req1_q.cyc) begin
                    next_owner = prefer1 ? cache_mem_pkg::o_input1 : cache_mem_pkg::o_input0;
                end else if (req0_q.cyc) begin
                    next_owner = cache_mem_pkg::o_input0;
                end else if (req1_q.cyc) begin
                    next_owner = cache_mem_pkg::o_input1;
                end
            end
            cache_mem_pkg::o_input0: begin
                if (!req0_q.cyc) begin                  // released, other side next
                    next_owner = req1_q.cyc ? cache_mem_pkg::o_input1 : cache_mem_pkg::o_none;
                end
            end
            cache_mem_pkg::o_input1: begin
                if (!req1_q.cyc) begin
                    next_owner = req0_q.cyc ? cache_mem_pkg::o_input0 : cache_mem_pkg::o_none;
                end
            end
            default: next_owner = cache_mem_pkg::o_none;
        endcase
    end

    assign new_grant = (next_owner != cache_mem_pkg::o_none) && (next_owner != owner);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            owner         <= cache_mem_pkg::o_none;
            o_grant       <= 1'b0;
            o_grant_owner <= cache_mem_pkg::o_none;
            last_was0     <= 1'b0;      // so port 0 takes the first tie
        end else begin
            owner         <= next_owner;
            o_grant       <= new_grant;  // pulse as the owner takes over
            o_grant_owner <= new_grant ? next_owner : cache_mem_pkg::o_none;
            if (new_grant) begin
                last_was0 <= (next_owner == cache_mem_pkg::o_input0);
            end
        end
    end

    // owner passes through, everyone else retries
    always_comb begin
        o_mem   = '0;
        o_port0 = rsp_idle;
        o_port1 = rsp_idle;
        case (owner)
            cache_mem_pkg::o_input0: begin
                o_mem   = req0_q;
                o_port0 = rsp_q;
            end
            cache_mem_pkg::o_input1: begin
                o_mem   = req1_q;
                o_port1 = rsp_q;
            end
            default: begin
                o_mem = '0;                 // bus idle
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/arb_config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_mem_macros.svh"

module arb_config_regs (
    input  wire                           clk,
    input  wire                           i_reset,
    input  cache_mem_pkg::cfg_req_t       i_cfg,
    output cache_mem_pkg::cfg_rsp_t       o_cfg,
    output cache_mem_pkg::arb_mode_t      o_mode,
    input  wire                           i_grant,
    input  cache_mem_pkg::owner_t         i_grant_owner
);

    localparam logic [`CFG_ADDR_BITS-1:0] addr_mode  = 2'd0;
    localparam logic [`CFG_ADDR_BITS-1:0] addr_cnt0  = 2'd1;
    localparam logic [`CFG_ADDR_BITS-1:0] addr_cnt1  = 2'd2;
    localparam logic [`CFG_ADDR_BITS-1:0] addr_clear = 2'd3;

    logic [`CFG_DATA_BITS-1:0] grant_cnt [2];
    logic [`CFG_DATA_BITS-1:0] rd_mux;
    logic [`CFG_DATA_BITS-1:0] rdata_q;
    logic [1:0]                hit;       // grant for port 0 / port 1
    logic                      wr;
    logic                      clear;
    logic                      ack_q;

    assign wr    = i_cfg.stb && i_cfg.we;
    assign clear = wr && (i_cfg.adr == addr_clear);

    assign hit[0] = i_grant && (i_grant_owner == cache_mem_pkg::o_input0);
    assign hit[1] = i_grant && (i_grant_owner == cache_mem_pkg::o_input1);

    always_comb begin
        case (i_cfg.adr)
            addr_mode: rd_mux = {{(`CFG_DATA_BITS-1){1'b0}}, o_mode};
            addr_cnt0: rd_mux = grant_cnt[0];
            addr_cnt1: rd_mux = grant_cnt[1];
            default:   rd_mux = '0;          // clear reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ack_q        <= 1'b0;
            o_mode       <= cache_mem_pkg::mode_fixed;
            grant_cnt[0] <= '0;
            grant_cnt[1] <= '0;
        end else begin
            ack_q <= i_cfg.stb;              // single cycle access
            if (wr && (i_cfg.adr == addr_mode)) begin
                o_mode <= cache_mem_pkg::arb_mode_t'(i_cfg.wdata[0]);
            end
            for (int p = 0; p < 2; p++) begin
                if (clear) begin
                    grant_cnt[p] <= '0;      // same-cycle grant is lost
                end else if (hit[p] && (grant_cnt[p] != '1)) begin
                    grant_cnt[p] <= grant_cnt[p] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_cfg.stb) begin
            rdata_q <= i_cfg.we ? '0 : rd_mux;
        end
    end

    assign o_cfg = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* source/line_memory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_mem_macros.svh"

module line_memory (
    input  wire                    clk,
    input  wire                    i_reset,
    input  cache_mem_pkg::wb_req_t i_req,
    output cache_mem_pkg::wb_rsp_t o_rsp
);

    localparam int idx_bits = $clog2(`MEM_LINES);
    localparam int cnt_bits = $clog2(`MEM_WAIT + 1);

    logic [`LINE_BITS-1:0]      mem [`MEM_LINES];
    logic [`LINE_ADDR_BITS-1:0] adr_q;       // access captured at start
    logic                       we_q;
    logic [`SEL_BITS-1:0]       sel_q;
    logic [`LINE_BITS-1:0]      dat_q;
    logic [`LINE_BITS-1:0]      rdata_q;
    logic [idx_bits-1:0]        idx;
    logic [cnt_bits-1:0]        wait_cnt;
    logic                       stb_d;       // for rising edge of stb
    logic                       busy;
    logic                       ack_q;
    logic                       start;
    logic                       done;

    assign start = i_req.cyc && i_req.stb && !stb_d && !busy;
    assign done  = busy && (wait_cnt == '0);
    assign idx   = adr_q[idx_bits-1:0];     // upper address bits alias

    always_ff @(posedge clk) begin
        if (i_reset) begin
            stb_d    <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            stb_d <= i_req.stb;
            ack_q <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                wait_cnt <= cnt_bits'(`MEM_WAIT - 1);
            end else if (done) begin
                busy  <= 1'b0;
                ack_q <= 1'b1;                // one cycle pulse
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // array and payload, no reset
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= i_req.adr;
            we_q  <= i_req.we;
            sel_q <= i_req.sel;
            dat_q <= i_req.dat_m;
        end
        if (done) begin
            if (we_q) begin
                for (int b = 0; b < `SEL_BITS; b++) begin
                    if (sel_q[b]) begin
                        mem[idx][b*8 +: 8] <= dat_q[b*8 +: 8];   // byte merge
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign o_rsp = '{dat_s: rdata_q, ack: ack_q, rty: 1'b0};

endmodule

`default_nettype wire

/* source/cache_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_mem_top (
    input  wire                     clk,
    input  wire                     i_reset,
    input  cache_mem_pkg::wb_req_t  i_port0,    // instruction cache side
    input  cache_mem_pkg::wb_req_t  i_port1,    // data cache side
    output cache_mem_pkg::wb_rsp_t  o_port0,
    output cache_mem_pkg::wb_rsp_t  o_port1,
    input  cache_mem_pkg::cfg_req_t i_cfg,
    output cache_mem_pkg::cfg_rsp_t o_cfg
);

    cache_mem_pkg::wb_req_t    mem_req;
    cache_mem_pkg::wb_rsp_t    mem_rsp;
    cache_mem_pkg::arb_mode_t  mode;
    cache_mem_pkg::owner_t     grant_owner;
    logic                      grant;

    cache_arbiter u_arbiter (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_port0       (i_port0),
        .i_port1       (i_port1),
        .o_port0       (o_port0),
        .o_port1       (o_port1),
        .o_mem         (mem_req),
        .i_mem         (mem_rsp),
        .i_mode        (mode),
        .o_grant       (grant),
        .o_grant_owner (grant_owner)
    );

    arb_config_regs u_config (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_cfg         (i_cfg),
        .o_cfg         (o_cfg),
        .o_mode        (mode),
        .i_grant       (grant),
        .i_grant_owner (grant_owner)
    );

    line_memory u_memory (
        .clk     (clk),
        .i_reset (i_reset),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

/* bench/cache_mem_sva.sv */
`timescale 1ns/100ps
`default_nettype none

// protocol checks bound onto cache_mem_top
module cache_mem_sva (
    input wire                     clk,
    input wire                     i_reset,
    input cache_mem_pkg::wb_req_t  i_req0,
    input cache_mem_pkg::wb_req_t  i_req1,
    input cache_mem_pkg::wb_rsp_t  i_rsp0,
    input cache_mem_pkg::wb_rsp_t  i_rsp1,
    input cache_mem_pkg::wb_req_t  i_mem_req,
    input cache_mem_pkg::cfg_req_t i_cfg_req,
    input cache_mem_pkg::cfg_rsp_t i_cfg_rsp
);

    int fail_count = 0;                // failed protocol checks so far

    acks_exclusive: assert property (@(posedge clk) disable iff (i_reset)
        !(i_rsp0.ack && i_rsp1.ack))
        else begin
            $error("both cache ports acknowledged in the same cycle");
            fail_count++;
        end

    ack0_not_retried: assert property (@(posedge clk) disable iff (i_reset)
        i_rsp0.ack |-> !i_rsp0.rty)
        else begin
            $error("port 0 acknowledged while retried");
            fail_count++;
        end

    ack1_not_retried: assert property (@(posedge clk) disable iff (i_reset)
        i_rsp1.ack |-> !i_rsp1.rty)
        else begin
            $error("port 1 acknowledged while retried");
            fail_count++;
        end

    // exactly one port is out of retry while the memory bus is busy
    mem_single_owner: assert property (@(posedge clk) disable iff (i_reset)
        i_mem_req.cyc |-> (i_rsp0.rty != i_rsp1.rty))
        else begin
            $error("memory cycle without a single owner");
            fail_count++;
        end

    mem_from_port0: assert property (@(posedge clk) disable iff (i_reset)
        (i_mem_req.cyc && !i_rsp0.rty) |-> $past(i_req0.cyc))
        else begin
            $error("memory cycle not requested by owner port 0");
            fail_count++;
        end

    mem_from_port1: assert property (@(posedge clk) disable iff (i_reset)
        (i_mem_req.cyc && !i_rsp1.rty) |-> $past(i_req1.cyc))
        else begin
            $error("memory cycle not requested by owner port 1");
            fail_count++;
        end

    cfg_ack_follows: assert property (@(posedge clk) disable iff (i_reset)
        i_cfg_req.stb |=> i_cfg_rsp.ack)
        else begin
            $error("config ack missing one cycle after strobe");
            fail_count++;
        end

    cfg_ack_caused: assert property (@(posedge clk) disable iff (i_reset)
        i_cfg_rsp.ack |-> $past(i_cfg_req.stb))
        else begin
            $error("config ack without a strobe one cycle before");
            fail_count++;
        end

endmodule

`default_nettype wire

/* bench/cache_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_mem_macros.svh"

module cache_mem_tb;

    localparam int ack_timeout = 64;   // cycles, covers a handover
    localparam int cfg_timeout = 8;
    localparam int line_count  = 6;

    logic                    clk;
    logic                    i_reset;
    cache_mem_pkg::wb_req_t  i_port0;
    cache_mem_pkg::wb_req_t  i_port1;
    cache_mem_pkg::wb_rsp_t  o_port0;
    cache_mem_pkg::wb_rsp_t  o_port1;
    cache_mem_pkg::cfg_req_t i_cfg;
    cache_mem_pkg::cfg_rsp_t o_cfg;

    logic [`LINE_BITS-1:0]      shadow [`MEM_LINES];   // expected memory lines
    logic [`LINE_ADDR_BITS-1:0] known_adr;
    int grants_exp [2];                                  // ownership periods per port
    int last_owner   = 1;                                // arbiter starts as if port 1 was last
    int cycle        = 0;
    int errors       = 0;
    int errors_mark  = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    cache_mem_top DUT (
        .clk     (clk),
        .i_reset (i_reset),
        .i_port0 (i_port0),
        .i_port1 (i_port1),
        .o_port0 (o_port0),
        .o_port1 (o_port1),
        .i_cfg   (i_cfg),
        .o_cfg   (o_cfg)
    );

    bind cache_mem_top cache_mem_sva u_sva (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_req0    (i_port0),
        .i_req1    (i_port1),
        .i_rsp0    (o_port0),
        .i_rsp1    (o_port1),
        .i_mem_req (mem_req),
        .i_cfg_req (i_cfg),
        .i_cfg_rsp (o_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;                 // read at negedge only
    end

    function automatic logic [`LINE_BITS-1:0] rand_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [`LINE_ADDR_BITS-1:0] rand_adr();
        logic [31:0] r;
        r = $urandom;
        return r[`LINE_ADDR_BITS-1:0];
    endfunction

    function automatic void merge_shadow(input logic [`LINE_ADDR_BITS-1:0] adr,
                                         input logic [`SEL_BITS-1:0] sel,
                                         input logic [`LINE_BITS-1:0] data);
        for (int b = 0; b < `SEL_BITS; b++) begin
            if (sel[b]) begin
                shadow[adr % `MEM_LINES][b*8 +: 8] = data[b*8 +: 8];   // low bits index
            end
        end
    endfunction

    task automatic compare_value(input string name, input logic [`LINE_BITS-1:0] exp,
                                 input logic [`LINE_BITS-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_true(input string name, input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s: %s", name, what);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drive_port(input int port, input cache_mem_pkg::wb_req_t req);
        if (port == 0) begin
            i_port0 <= req;
        end else begin
            i_port1 <= req;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        i_reset <= 1'b1;
        wait_cycles(4);                     // four sampled edges
        i_reset <= 1'b0;
        grants_exp[0] = 0;
        grants_exp[1] = 0;
        last_owner    = 1;
    endtask

    // one whole-line access, cyc held from request to ack
    task automatic line_access(input int port, input logic we,
                               input logic [`LINE_ADDR_BITS-1:0] adr,
                               input logic [`SEL_BITS-1:0] sel,
                               input logic [`LINE_BITS-1:0] data,
                               output logic [`LINE_BITS-1:0] rdata,
                               output int ack_cyc, output int free_cyc);
        cache_mem_pkg::wb_req_t req;
        cache_mem_pkg::wb_rsp_t rsp;
        int   waited;
        logic seen;
        req       = '0;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.sel   = sel;
        req.adr   = adr;
        req.dat_m = data;
        rdata     = '0;
        ack_cyc   = -1;
        free_cyc  = -1;
        waited    = 0;
        seen      = 1'b0;
        @(posedge clk);
        drive_port(port, req);
        while (!seen && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
            rsp = (port == 0) ? o_port0 : o_port1;
            if (!rsp.rty && free_cyc < 0) begin
                free_cyc = cycle;           // first cycle as owner
            end
            if (rsp.ack) begin
                seen    = 1'b1;
                rdata   = rsp.dat_s;
                ack_cyc = cycle;
            end
        end
        @(posedge clk);
        drive_port(port, '0);               // stb and cyc drop together
        if (seen) begin
            grants_exp[port]++;
            last_owner = port;
        end else begin
            $display("timeout: port %0d got no ack within %0d cycles", port, ack_timeout);
            errors++;
        end
    endtask

    task automatic cfg_access(input logic we, input logic [`CFG_ADDR_BITS-1:0] adr,
                              input logic [`CFG_DATA_BITS-1:0] wdata,
                              output logic [`CFG_DATA_BITS-1:0] rdata);
        cache_mem_pkg::cfg_req_t req;
        int   waited;
        logic seen;
        req.stb   = 1'b1;
        req.we    = we;
        req.adr   = adr;
        req.wdata = wdata;
        rdata     = '0;
        waited    = 0;
        seen      = 1'b0;
        @(posedge clk);
        i_cfg <= req;
        @(posedge clk);
        i_cfg <= '0;                        // strobe lasts one cycle
        while (!seen && waited < cfg_timeout) begin
            @(negedge clk);
            waited++;
            if (o_cfg.ack) begin
                seen  = 1'b1;
                rdata = o_cfg.rdata;
            end
        end
        if (!seen) begin
            $display("timeout: config access to register %0d got no ack", adr);
            errors++;
        end
    endtask

    // both ports request in the same cycle from idle, to distinct lines
    task automatic race_ports(output int first, output int ack0, output int ack1,
                              output int free1);
        logic [`LINE_ADDR_BITS-1:0] adr0;
        logic [`LINE_ADDR_BITS-1:0] adr1;
        logic [`LINE_BITS-1:0]      d0;
        logic [`LINE_BITS-1:0]      d1;
        logic [`LINE_BITS-1:0]      got0;
        logic [`LINE_BITS-1:0]      got1;
        int a0;
        int a1;
        int f0;
        int f1;
        adr0 = rand_adr();
        adr1 = adr0 ^ 1;
        d0   = rand_line();
        d1   = rand_line();
        wait_cycles(4);                     // arbiter back to no owner
        fork
            line_access(0, 1'b1, adr0, '1, d0, got0, a0, f0);
            line_access(1, 1'b1, adr1, '1, d1, got1, a1, f1);
        join
        merge_shadow(adr0, '1, d0);
        merge_shadow(adr1, '1, d1);
        first = (a1 >= 0 && (a0 < 0 || a1 < a0)) ? 1 : 0;
        ack0  = a0;
        ack1  = a1;
        free1 = f1;
    endtask

    task automatic report_test(input string name);
        int n;
        n = errors - errors_mark;
        tests_run++;
        if (n == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d error(s)", name, n);
            tests_failed++;
        end
        errors_mark = errors;
    endtask

    task automatic write_read_lines();
        logic [`LINE_ADDR_BITS-1:0] adr [line_count];
        logic [`LINE_BITS-1:0]      data;
        logic [`LINE_BITS-1:0]      got;
        int a;
        int f;
        for (int i = 0; i < line_count; i++) begin
            adr[i] = rand_adr();
            data   = rand_line();
            line_access(0, 1'b1, adr[i], '1, data, got, a, f);
            merge_shadow(adr[i], '1, data);
            wait_cycles(2);
        end
        for (int i = 0; i < line_count; i++) begin
            line_access(0, 1'b0, adr[i], '0, '0, got, a, f);
            compare_value("write_read_lines", shadow[adr[i] % `MEM_LINES], got);
            wait_cycles(2);
        end
        known_adr = adr[0];
        report_test("write_read_lines");
    endtask

    task automatic merge_bytes();
        logic [`LINE_ADDR_BITS-1:0] adr;
        logic [`SEL_BITS-1:0]       sel;
        logic [`LINE_BITS-1:0]      data;
        logic [`LINE_BITS-1:0]      got;
        logic [31:0]                r;
        int a;
        int f;
        for (int i = 0; i < 4; i++) begin
            adr  = rand_adr();
            data = rand_line();
            line_access(0, 1'b1, adr, '1, data, got, a, f);   // known base line
            merge_shadow(adr, '1, data);
            r    = $urandom;
            sel  = r[`SEL_BITS-1:0];
            data = rand_line();
            line_access(0, 1'b1, adr, sel, data, got, a, f);
            merge_shadow(adr, sel, data);
            line_access(0, 1'b0, adr, '0, '0, got, a, f);
            compare_value("merge_bytes", shadow[adr % `MEM_LINES], got);
            wait_cycles(2);
        end
        report_test("merge_bytes");
    endtask

    task automatic fixed_priority_race();
        logic [`LINE_BITS-1:0] got;
        int first;
        int ack0;
        int ack1;
        int free1;
        int a;
        int f;
        race_ports(first, ack0, ack1, free1);
        compare_value("fixed_priority_race", 0, first);
        expect_true("fixed_priority_race", free1 > ack0 + 1,
                    "port 1 left retry before port 0 dropped cyc");
        line_access(1, 1'b0, known_adr, '0, '0, got, a, f);   // read path of port 1
        compare_value("fixed_priority_race port 1 read",
                      shadow[known_adr % `MEM_LINES], got);
        report_test("fixed_priority_race");
    endtask

    task automatic alternate_priority();
        logic [`CFG_DATA_BITS-1:0] rd;
        logic [`LINE_ADDR_BITS-1:0] adr;
        logic [`LINE_BITS-1:0]      data;
        logic [`LINE_BITS-1:0]      got;
        int first;
        int expected;
        int ack0;
        int ack1;
        int free1;
        int a;
        int f;
        cfg_access(1'b1, 0, 1, rd);
        cfg_access(1'b0, 0, 0, rd);
        compare_value("alternate_priority mode", 1, rd);
        for (int r = 0; r < 4; r++) begin
            if (r == 1) begin
                adr  = rand_adr();          // port 0 alone, so port 1 is due next
                data = rand_line();
                line_access(0, 1'b1, adr, '1, data, got, a, f);
                merge_shadow(adr, '1, data);
            end
            expected = 1 - last_owner;      // tie goes to the port not granted last
            race_ports(first, ack0, ack1, free1);
            compare_value("alternate_priority", expected, first);
        end
        report_test("alternate_priority");
    endtask

    task automatic grant_counters();
        logic [`CFG_DATA_BITS-1:0] rd;
        wait_cycles(4);
        cfg_access(1'b0, 1, 0, rd);
        compare_value("grant_counters port 0", grants_exp[0], rd);
        cfg_access(1'b0, 2, 0, rd);
        compare_value("grant_counters port 1", grants_exp[1], rd);
        cfg_access(1'b1, 3, 0, rd);         // any value clears
        grants_exp[0] = 0;
        grants_exp[1] = 0;
        cfg_access(1'b0, 1, 0, rd);
        compare_value("grant_counters cleared 0", 0, rd);
        cfg_access(1'b0, 2, 0, rd);
        compare_value("grant_counters cleared 1", 0, rd);
        report_test("grant_counters");
    endtask

    task automatic reset_idle();
        logic [`CFG_DATA_BITS-1:0] rd;
        logic [`LINE_BITS-1:0]     got;
        logic done;
        int stray;
        int n;
        int a;
        int f;
        done  = 1'b0;
        stray = 0;
        n     = 0;
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            compare_value("reset_idle ack0", 0, o_port0.ack);
            compare_value("reset_idle ack1", 0, o_port1.ack);
        end
        cfg_access(1'b0, 0, 0, rd);
        compare_value("reset_idle mode", 0, rd);
        fork
            begin
                line_access(0, 1'b0, known_adr, '0, '0, got, a, f);
                done = 1'b1;
            end
            begin
                while (!done && n < ack_timeout + 4) begin
                    @(negedge clk);
                    n++;
                    if (o_port1.ack) begin
                        stray++;            // port 1 never raised cyc
                    end
                end
            end
        join
        compare_value("reset_idle read", shadow[known_adr % `MEM_LINES], got);
        expect_true("reset_idle", stray == 0, "idle port 1 was acknowledged with cyc low");
        report_test("reset_idle");
    endtask

    initial begin
        i_reset = 1'b1;
        i_port0 = '0;
        i_port1 = '0;
        i_cfg   = '0;
        void'($urandom(97467));
        apply_reset();
        write_read_lines();
        merge_bytes();
        fixed_priority_race();
        alternate_priority();
        grant_counters();
        reset_idle();
        errors = errors + DUT.u_sva.fail_count;   // bound protocol checks
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cache_mem_sys.f */
+incdir+include
source/cache_mem_pkg.sv
source/wb_barrier.sv
source/cache_arbiter.sv
source/arb_config_regs.sv
source/line_memory.sv
source/cache_mem_top.sv
bench/cache_mem_sva.sv
bench/cache_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cache memory subsystem testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cache_mem_tb \
    -f cache_mem_sys.f -o cache_mem_sim > build.log 2>&1 \
    && ./obj_dir/cache_mem_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log and sim.log"
grep -q "STATUS: PASS" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
